//--- hdl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

   // Major opcodes
   localparam logic [6:0] op_reg    = 7'b0110011;
   localparam logic [6:0] op_imm    = 7'b0010011;
   localparam logic [6:0] op_load   = 7'b0000011;
   localparam logic [6:0] op_store  = 7'b0100011;
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_auipc  = 7'b0010111;
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_jalr   = 7'b1100111;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_system = 7'b1110011;

   // ALU operation codes
   localparam logic [4:0] alu_add     = 5'd0;
   localparam logic [4:0] alu_sub     = 5'd1;
   localparam logic [4:0] alu_and     = 5'd2;
   localparam logic [4:0] alu_or      = 5'd3;
   localparam logic [4:0] alu_xor     = 5'd4;
   localparam logic [4:0] alu_sll     = 5'd5;
   localparam logic [4:0] alu_srl     = 5'd6;
   localparam logic [4:0] alu_sra     = 5'd7;
   localparam logic [4:0] alu_slt     = 5'd8;
   localparam logic [4:0] alu_sltu    = 5'd9;
   localparam logic [4:0] alu_lui     = 5'd10; // Passes imm << 12
   localparam logic [4:0] alu_mul     = 5'd11;
   localparam logic [4:0] alu_mulh    = 5'd12;
   localparam logic [4:0] alu_mulhsu  = 5'd13;
   localparam logic [4:0] alu_mulhu   = 5'd14;
   localparam logic [4:0] alu_invalid = 5'd31;

   // Write-back source
   localparam logic [1:0] wb_mem = 2'd0;
   localparam logic [1:0] wb_alu = 2'd1;
   localparam logic [1:0] wb_pc4 = 2'd2;
   localparam logic [1:0] wb_csr = 2'd3;

   // Divider modes
   localparam logic [1:0] div_div  = 2'd0;
   localparam logic [1:0] div_divu = 2'd1;
   localparam logic [1:0] div_rem  = 2'd2;
   localparam logic [1:0] div_remu = 2'd3;

   // CSR operations
   localparam logic [2:0] csr_nop = 3'd0;
   localparam logic [2:0] csr_rw  = 3'd1;
   localparam logic [2:0] csr_rs  = 3'd2;
   localparam logic [2:0] csr_rc  = 3'd3;
   localparam logic [2:0] csr_rwi = 3'd4;
   localparam logic [2:0] csr_rsi = 3'd5;
   localparam logic [2:0] csr_rci = 3'd6;

   localparam logic [6:0] f7_base   = 7'b0000000;
   localparam logic [6:0] f7_alt    = 7'b0100000; // SUB and SRA
   localparam logic [6:0] f7_muldiv = 7'b0000001;

   // funct12 of the privileged SYSTEM forms
   localparam logic [11:0] sys_ecall = 12'h000;
   localparam logic [11:0] sys_mret  = 12'h302;

   // One instruction word, register and immediate layouts
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm12; // CSR address or funct12
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
   } instr_u;

endpackage

`default_nettype wire

//--- hdl/alu_op_decode.sv
`default_nettype none
`timescale 1ns/1ns

module alu_op_decode #(
   parameter bit has_mul_div = 1'b1
) (
   input  logic [2:0] funct3,
   input  logic [6:0] funct7,
   input  logic       use_imm,
   output logic [4:0] alu_sel,
   output logic       is_div,
   output logic [1:0] div_mode
);
   import ctrl_pkg::*;

   always_comb begin
      alu_sel  = alu_invalid;
      is_div   = 1'b0;
      div_mode = div_div;
      if (use_imm) begin
         case (funct3)
            3'b000: alu_sel = alu_add;
            3'b001: alu_sel = alu_sll;
            3'b010: alu_sel = alu_slt;
            3'b011: alu_sel = alu_sltu;
            3'b100: alu_sel = alu_xor;
            3'b101: begin
               if (funct7 == f7_base) begin
                  alu_sel = alu_srl;
               end else if (funct7 == f7_alt) begin
                  alu_sel = alu_sra;
               end
            end
            3'b110: alu_sel = alu_or;
            default: alu_sel = alu_and;
         endcase
      end else if (funct7 == f7_base) begin
         case (funct3)
            3'b000: alu_sel = alu_add;
            3'b001: alu_sel = alu_sll;
            3'b010: alu_sel = alu_slt;
            3'b011: alu_sel = alu_sltu;
            3'b100: alu_sel = alu_xor;
            3'b101: alu_sel = alu_srl;
            3'b110: alu_sel = alu_or;
            default: alu_sel = alu_and;
         endcase
      end else if (funct7 == f7_alt) begin
         if (funct3 == 3'b000) begin
            alu_sel = alu_sub;
         end else if (funct3 == 3'b101) begin
            alu_sel = alu_sra;
         end
      end else if (funct7 == f7_muldiv && has_mul_div) begin
         // Upper half of funct3 goes to the divider
         case (funct3)
            3'b000: alu_sel = alu_mul;
            3'b001: alu_sel = alu_mulh;
            3'b010: alu_sel = alu_mulhsu;
            3'b011: alu_sel = alu_mulhu;
            3'b100: div_mode = div_div;
            3'b101: div_mode = div_divu;
            3'b110: div_mode = div_rem;
            default: div_mode = div_remu;
         endcase
         is_div = funct3[2];
      end
   end

endmodule

`default_nettype wire

//--- hdl/system_decode.sv
`default_nettype none
`timescale 1ns/1ns

module system_decode (
   input  logic [2:0]  funct3,
   input  logic [11:0] imm12,
   input  logic [4:0]  rd,
   input  logic [4:0]  rs1,
   output logic        csr_we,
   output logic [11:0] csr_addr,
   output logic [2:0]  csr_op,
   output logic        rd_write,
   output logic [1:0]  wb_sel,
   output logic        trap_req,
   output logic        mret_exec,
   output logic        flush
);
   import ctrl_pkg::*;

   logic csr_form;
   logic write_form;

   always_comb begin
      case (funct3)
         3'b001: csr_op = csr_rw;
         3'b010: csr_op = csr_rs;
         3'b011: csr_op = csr_rc;
         3'b101: csr_op = csr_rwi;
         3'b110: csr_op = csr_rsi;
         3'b111: csr_op = csr_rci;
         default: csr_op = csr_nop; // ECALL/MRET and funct3 4
      endcase
   end

   assign csr_form   = (csr_op != csr_nop);
   assign write_form = (csr_op == csr_rw) || (csr_op == csr_rwi);

   always_comb begin
      csr_we    = 1'b0;
      csr_addr  = 12'd0;
      rd_write  = 1'b0;
      wb_sel    = wb_mem;
      trap_req  = 1'b0;
      mret_exec = 1'b0;
      flush     = 1'b0;
      if (csr_form) begin
         csr_addr = imm12;
         wb_sel   = wb_csr; // Old CSR value to rd
         csr_we   = write_form ? 1'b1 : (rs1 != 5'd0);
         rd_write = write_form ? (rd != 5'd0) : 1'b1;
      end else if (funct3 == 3'b000) begin
         if (imm12 == sys_ecall) begin
            trap_req = 1'b1;
            flush    = 1'b1;
         end else if (imm12 == sys_mret) begin
            mret_exec = 1'b1;
            flush     = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/control_unit.sv
`default_nettype none
`timescale 1ns/1ns

module control_unit #(
   parameter bit has_mul_div = 1'b1
) (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             instr_valid,
   input  ctrl_pkg::instr_u instr,
   output logic             ctrl_valid,
   output logic             reg_wen,
   output logic             mem_write,
   output logic             mem_read,
   output logic             a_sel,
   output logic             b_sel,
   output logic [1:0]       wb_sel,
   output logic [4:0]       alu_sel,
   output logic             br_un,
   output logic             branch,
   output logic             is_jalr,
   output logic             flush,
   output logic             is_div,
   output logic [1:0]       div_mode,
   output logic             csr_we,
   output logic [11:0]      csr_addr,
   output logic [2:0]       csr_op,
   output logic             trap_req,
   output logic             mret_exec
);
   import ctrl_pkg::*;

   logic        use_imm;
   logic [4:0]  dec_alu_sel;
   logic        dec_is_div;
   logic [1:0]  dec_div_mode;
   logic        sys_csr_we;
   logic [11:0] sys_csr_addr;
   logic [2:0]  sys_csr_op;
   logic        sys_rd_write;
   logic [1:0]  sys_wb_sel;
   logic        sys_trap_req;
   logic        sys_mret_exec;
   logic        sys_flush;

   logic        reg_wen_d, mem_write_d, mem_read_d, a_sel_d, b_sel_d;
   logic        br_un_d, branch_d, is_jalr_d, flush_d, is_div_d;
   logic        csr_we_d, trap_req_d, mret_exec_d;
   logic [1:0]  wb_sel_d;
   logic [4:0]  alu_sel_d;
   logic [1:0]  div_mode_d;
   logic [11:0] csr_addr_d;
   logic [2:0]  csr_op_d;

   assign use_imm = (instr.r.opcode == op_imm);

   alu_op_decode #(
      .has_mul_div(has_mul_div)
   ) i_alu_op_decode (
      .funct3  (instr.r.funct3),
      .funct7  (instr.r.funct7),
      .use_imm (use_imm),
      .alu_sel (dec_alu_sel),
      .is_div  (dec_is_div),
      .div_mode(dec_div_mode)
   );

   system_decode i_system_decode (
      .funct3   (instr.i.funct3),
      .imm12    (instr.i.imm12),
      .rd       (instr.i.rd),
      .rs1      (instr.i.rs1),
      .csr_we   (sys_csr_we),
      .csr_addr (sys_csr_addr),
      .csr_op   (sys_csr_op),
      .rd_write (sys_rd_write),
      .wb_sel   (sys_wb_sel),
      .trap_req (sys_trap_req),
      .mret_exec(sys_mret_exec),
      .flush    (sys_flush)
   );

   always_comb begin
      reg_wen_d   = 1'b0;
      mem_write_d = 1'b0;
      mem_read_d  = 1'b0;
      a_sel_d     = 1'b0; // rs1
      b_sel_d     = 1'b0; // rs2
      wb_sel_d    = wb_mem;
      alu_sel_d   = alu_add; // Address sums by default
      br_un_d     = 1'b0;
      branch_d    = 1'b0;
      is_jalr_d   = 1'b0;
      flush_d     = 1'b0;
      is_div_d    = 1'b0;
      div_mode_d  = div_div;
      csr_we_d    = 1'b0;
      csr_addr_d  = 12'd0;
      csr_op_d    = csr_nop;
      trap_req_d  = 1'b0;
      mret_exec_d = 1'b0;
      case (instr.r.opcode)
         op_reg, op_imm: begin
            reg_wen_d  = 1'b1;
            b_sel_d    = use_imm;
            wb_sel_d   = wb_alu;
            alu_sel_d  = dec_alu_sel;
            is_div_d   = dec_is_div;
            div_mode_d = dec_div_mode;
         end
         op_load: begin
            reg_wen_d  = 1'b1;
            mem_read_d = 1'b1;
            b_sel_d    = 1'b1;
         end
         op_store: begin
            mem_write_d = 1'b1;
            b_sel_d     = 1'b1;
         end
         op_lui: begin
            reg_wen_d = 1'b1;
            b_sel_d   = 1'b1;
            wb_sel_d  = wb_alu;
            alu_sel_d = alu_lui;
         end
         op_auipc: begin
            reg_wen_d = 1'b1;
            a_sel_d   = 1'b1; // PC + imm
            b_sel_d   = 1'b1;
            wb_sel_d  = wb_alu;
         end
         op_jal: begin
            reg_wen_d = 1'b1;
            a_sel_d   = 1'b1;
            b_sel_d   = 1'b1;
            wb_sel_d  = wb_pc4;
            flush_d   = 1'b1; // Drop the fall-through fetch
         end
         op_jalr: begin
            reg_wen_d = 1'b1;
            b_sel_d   = 1'b1;
            wb_sel_d  = wb_pc4;
            is_jalr_d = 1'b1;
            flush_d   = 1'b1;
         end
         op_branch: begin
            branch_d = 1'b1;
            a_sel_d  = 1'b1;
            b_sel_d  = 1'b1;
            br_un_d  = instr.r.funct3[2] & instr.r.funct3[1]; // BLTU, BGEU
         end
         op_system: begin
            reg_wen_d   = sys_rd_write;
            wb_sel_d    = sys_wb_sel;
            alu_sel_d   = alu_invalid;
            flush_d     = sys_flush;
            csr_we_d    = sys_csr_we;
            csr_addr_d  = sys_csr_addr;
            csr_op_d    = sys_csr_op;
            trap_req_d  = sys_trap_req;
            mret_exec_d = sys_mret_exec;
         end
         default: alu_sel_d = alu_invalid;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ctrl_valid <= 1'b0;
         reg_wen    <= 1'b0;
         mem_write  <= 1'b0;
         mem_read   <= 1'b0;
         a_sel      <= 1'b0;
         b_sel      <= 1'b0;
         wb_sel     <= 2'd0;
         alu_sel    <= 5'd0;
         br_un      <= 1'b0;
         branch     <= 1'b0;
         is_jalr    <= 1'b0;
         flush      <= 1'b0;
         is_div     <= 1'b0;
         div_mode   <= 2'd0;
         csr_we     <= 1'b0;
         csr_addr   <= 12'd0;
         csr_op     <= 3'd0;
         trap_req   <= 1'b0;
         mret_exec  <= 1'b0;
      end else begin
         ctrl_valid <= instr_valid;
         if (instr_valid) begin // Hold last set between strobes
            reg_wen   <= reg_wen_d;
            mem_write <= mem_write_d;
            mem_read  <= mem_read_d;
            a_sel     <= a_sel_d;
            b_sel     <= b_sel_d;
            wb_sel    <= wb_sel_d;
            alu_sel   <= alu_sel_d;
            br_un     <= br_un_d;
            branch    <= branch_d;
            is_jalr   <= is_jalr_d;
            flush     <= flush_d;
            is_div    <= is_div_d;
            div_mode  <= div_mode_d;
            csr_we    <= csr_we_d;
            csr_addr  <= csr_addr_d;
            csr_op    <= csr_op_d;
            trap_req  <= trap_req_d;
            mret_exec <= mret_exec_d;
         end
      end
   end

endmodule

`default_nettype wire

//--- testbench/ctrl_checker.sv
`default_nettype none
`timescale 1ns/1ns

module ctrl_checker (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         instr_valid,
   input  logic [31:0]  instr,
   input  logic [127:0] test_name,
   input  logic         ctrl_valid,
   input  logic         reg_wen,
   input  logic         mem_write,
   input  logic         mem_read,
   input  logic         a_sel,
   input  logic         b_sel,
   input  logic [1:0]   wb_sel,
   input  logic [4:0]   alu_sel,
   input  logic         br_un,
   input  logic         branch,
   input  logic         is_jalr,
   input  logic         flush,
   input  logic         is_div,
   input  logic [1:0]   div_mode,
   input  logic         csr_we,
   input  logic [11:0]  csr_addr,
   input  logic [2:0]   csr_op,
   input  logic         trap_req,
   input  logic         mret_exec,
   output int           errors,
   output int           checks
);
   import ctrl_pkg::*;

   // Field order matches the packed control vector, MSB first
   string fnames [18] = '{"reg_wen", "mem_write", "mem_read", "a_sel", "b_sel", "wb_sel",
                          "alu_sel", "br_un", "branch", "is_jalr", "flush", "is_div",
                          "div_mode", "csr_we", "csr_addr", "csr_op", "trap_req",
                          "mret_exec"};
   int fw [18] = '{1, 1, 1, 1, 1, 2, 5, 1, 1, 1, 1, 1, 2, 1, 12, 3, 1, 1};

   int          err_cnt = 0;
   int          chk_cnt = 0;
   logic        exp_valid_q = 1'b0;
   logic [36:0] exp_vec_q = '0; // Last strobed decode, held like the DUT

   assign errors = err_cnt;
   assign checks = chk_cnt;

   function automatic logic [4:0] base_alu(input logic [2:0] f3);
      case (f3)
         3'd0: return alu_add;
         3'd1: return alu_sll;
         3'd2: return alu_slt;
         3'd3: return alu_sltu;
         3'd4: return alu_xor;
         3'd5: return alu_srl;
         3'd6: return alu_or;
         default: return alu_and;
      endcase
   endfunction

   function automatic logic [36:0] decode_model(input logic [31:0] w);
      logic [6:0]  opc;
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [11:0] imm;
      logic        rd_zero, rs1_zero;
      logic        r_wen, m_wr, m_rd, as, bs, bu, br, jr, fl, dv, cwe, trap, mret;
      logic [1:0]  wb, dm;
      logic [4:0]  alu;
      logic [11:0] caddr;
      logic [2:0]  cop;
      opc      = w[6:0];
      f3       = w[14:12];
      f7       = w[31:25];
      imm      = w[31:20];
      rd_zero  = (w[11:7] == 5'd0);
      rs1_zero = (w[19:15] == 5'd0);
      {r_wen, m_wr, m_rd, as, bs, bu, br, jr, fl, dv, cwe, trap, mret} = '0;
      wb    = wb_mem;
      dm    = div_div;
      alu   = alu_add; // Address sums
      caddr = 12'd0;
      cop   = csr_nop;
      case (opc)
         op_reg: begin
            r_wen = 1'b1;
            wb    = wb_alu;
            if (f7 == f7_base) begin
               alu = base_alu(f3);
            end else if (f7 == f7_alt) begin
               alu = (f3 == 3'd0) ? alu_sub : (f3 == 3'd5) ? alu_sra : alu_invalid;
            end else if (f7 == f7_muldiv && f3[2]) begin
               alu = alu_invalid;
               dv  = 1'b1;
               dm  = f3[1:0]; // DIV, DIVU, REM, REMU in order
            end else if (f7 == f7_muldiv) begin
               alu = alu_mul + {3'b000, f3[1:0]};
            end else begin
               alu = alu_invalid;
            end
         end
         op_imm: begin
            r_wen = 1'b1;
            bs    = 1'b1;
            wb    = wb_alu;
            if (f3 != 3'd5) begin
               alu = base_alu(f3);
            end else begin
               alu = (f7 == f7_base) ? alu_srl : (f7 == f7_alt) ? alu_sra : alu_invalid;
            end
         end
         op_load: {r_wen, m_rd, bs} = 3'b111;
         op_store: {m_wr, bs} = 2'b11;
         op_lui: begin
            {r_wen, bs} = 2'b11;
            wb  = wb_alu;
            alu = alu_lui;
         end
         op_auipc: begin
            {r_wen, as, bs} = 3'b111;
            wb = wb_alu;
         end
         op_jal: begin
            {r_wen, as, bs, fl} = 4'b1111;
            wb = wb_pc4;
         end
         op_jalr: begin
            {r_wen, bs, jr, fl} = 4'b1111;
            wb = wb_pc4;
         end
         op_branch: begin
            {br, as, bs} = 3'b111;
            bu = (f3 == 3'd6) || (f3 == 3'd7);
         end
         op_system: begin
            alu = alu_invalid;
            if (f3 == 3'd0) begin
               trap = (imm == sys_ecall);
               mret = (imm == sys_mret);
               fl   = trap || mret;
            end else if (f3 != 3'd4) begin
               caddr = imm;
               wb    = wb_csr;
               case (f3)
                  3'd1: cop = csr_rw;
                  3'd2: cop = csr_rs;
                  3'd3: cop = csr_rc;
                  3'd5: cop = csr_rwi;
                  3'd6: cop = csr_rsi;
                  default: cop = csr_rci;
               endcase
               if (f3[1:0] == 2'd1) begin // Plain write forms
                  cwe   = 1'b1;
                  r_wen = !rd_zero;
               end else begin
                  cwe   = !rs1_zero;
                  r_wen = 1'b1;
               end
            end
         end
         default: alu = alu_invalid;
      endcase
      return {r_wen, m_wr, m_rd, as, bs, wb, alu, bu, br, jr, fl, dv, dm, cwe, caddr, cop,
              trap, mret};
   endfunction

   task automatic compare_outputs(input logic exp_valid, input logic [36:0] exp_vec);
      logic [36:0] act_vec;
      logic [11:0] e;
      logic [11:0] a;
      int          pos;
      act_vec = {reg_wen, mem_write, mem_read, a_sel, b_sel, wb_sel, alu_sel, br_un, branch,
                 is_jalr, flush, is_div, div_mode, csr_we, csr_addr, csr_op, trap_req,
                 mret_exec};
      chk_cnt++;
      if (ctrl_valid !== exp_valid) begin
         err_cnt++;
         if (exp_valid) begin
            $display("Test %0s: ctrl_valid did not follow a strobe", test_name);
         end else begin
            $display("Test %0s: ctrl_valid came with no preceding strobe", test_name);
         end
      end
      pos = 37;
      for (int i = 0; i < 18; i++) begin
         pos = pos - fw[i];
         e   = 12'((exp_vec >> pos) & ((37'd1 << fw[i]) - 37'd1));
         a   = 12'((act_vec >> pos) & ((37'd1 << fw[i]) - 37'd1));
         if (a !== e) begin
            err_cnt++;
            $display("Fail %0s: %0s expected 0x%0h, actual 0x%0h", test_name, fnames[i], e, a);
         end
      end
   endtask

   // Result of a strobe is due one edge later
   always @(posedge clk) begin
      if (!arst_n) begin
         exp_valid_q <= 1'b0;
         exp_vec_q   <= '0;
      end else begin
         exp_valid_q <= instr_valid;
         if (instr_valid) begin
            exp_vec_q <= decode_model(instr);
         end
      end
   end

   // Registered outputs are settled mid-cycle
   always @(negedge clk) begin
      compare_outputs(exp_valid_q, exp_vec_q);
   end

endmodule

`default_nettype wire

//--- testbench/tb_control_unit.sv
`default_nettype none
`timescale 1ns/1ns

module tb_control_unit;
   import ctrl_pkg::*;

   localparam int t_alu     = 0;
   localparam int t_class   = 1;
   localparam int t_system  = 2;
   localparam int t_unknown = 3;
   localparam int t_timing  = 4;

   localparam int n_reset   = 8;
   localparam int n_alu     = 300;
   localparam int n_class   = 200;
   localparam int n_system  = 200;
   localparam int n_timing  = 200;
   localparam int n_unknown = 150;
   localparam int n_total   = n_reset + n_alu + n_class + n_system + n_timing + n_unknown;

   logic         clk = 1'b0;
   logic         arst_n;
   logic         instr_valid;
   logic [31:0]  instr;
   logic [127:0] test_name;
   logic [15:0]  lfsr = 16'd21780;
   int           tests_run = 0;
   int           errors;
   int           checks;

   logic        ctrl_valid, reg_wen, mem_write, mem_read, a_sel, b_sel, br_un, branch;
   logic        is_jalr, flush, is_div, csr_we, trap_req, mret_exec;
   logic [1:0]  wb_sel, div_mode;
   logic [4:0]  alu_sel;
   logic [11:0] csr_addr;
   logic [2:0]  csr_op;

   always #4 clk = ~clk;

   control_unit #(
      .has_mul_div(1'b1)
   ) i_control_unit (
      .clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .instr(instr),
      .ctrl_valid(ctrl_valid), .reg_wen(reg_wen), .mem_write(mem_write),
      .mem_read(mem_read), .a_sel(a_sel), .b_sel(b_sel), .wb_sel(wb_sel),
      .alu_sel(alu_sel), .br_un(br_un), .branch(branch), .is_jalr(is_jalr),
      .flush(flush), .is_div(is_div), .div_mode(div_mode), .csr_we(csr_we),
      .csr_addr(csr_addr), .csr_op(csr_op), .trap_req(trap_req), .mret_exec(mret_exec)
   );

   ctrl_checker i_ctrl_checker (
      .clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .instr(instr),
      .test_name(test_name), .ctrl_valid(ctrl_valid), .reg_wen(reg_wen),
      .mem_write(mem_write), .mem_read(mem_read), .a_sel(a_sel), .b_sel(b_sel),
      .wb_sel(wb_sel), .alu_sel(alu_sel), .br_un(br_un), .branch(branch),
      .is_jalr(is_jalr), .flush(flush), .is_div(is_div), .div_mode(div_mode),
      .csr_we(csr_we), .csr_addr(csr_addr), .csr_op(csr_op), .trap_req(trap_req),
      .mret_exec(mret_exec), .errors(errors), .checks(checks)
   );

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // x^16+x^14+x^13+x^11+1
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return v;
   endfunction

   function automatic logic is_listed(input logic [6:0] opc);
      case (opc)
         op_reg, op_imm, op_load, op_store, op_lui, op_auipc, op_jal, op_jalr, op_branch,
         op_system: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic [6:0] class_opcode(input int idx);
      case (idx)
         0: return op_load;
         1: return op_store;
         2: return op_lui;
         3: return op_auipc;
         4: return op_jal;
         5: return op_jalr;
         default: return op_branch;
      endcase
   endfunction

   function automatic logic [31:0] make_instr(input int kind);
      logic [31:0] w;
      logic [1:0]  sel;
      w   = random_bits(32);
      sel = 2'(random_bits(2));
      case (kind)
         t_alu: begin
            w[6:0] = random_bits(1) ? op_imm : op_reg;
            if (sel == 2'd0) w[31:25] = f7_base;
            else if (sel == 2'd1) w[31:25] = f7_alt;
            else if (sel == 2'd2) w[31:25] = f7_muldiv;
         end
         t_class: w[6:0] = class_opcode(int'(random_bits(3)) % 7);
         t_system: begin
            w[6:0] = op_system;
            if (sel[1] == 1'b0) begin
               w[14:12] = 3'd0;
               w[31:20] = sel[0] ? sys_mret : sys_ecall;
            end
            if (random_bits(1)) w[11:7] = 5'd0; // rd-zero rule
            if (random_bits(1)) w[19:15] = 5'd0; // rs1-zero rule
         end
         default: begin
            if (sel[1] == 1'b0) begin
               while (is_listed(w[6:0])) w[6:0] = 7'(random_bits(7));
            end else begin
               w[6:0]   = op_system;
               w[14:12] = sel[0] ? 3'd4 : 3'd0;
               while (w[31:20] == sys_ecall || w[31:20] == sys_mret) begin
                  w[31:20] = 12'(random_bits(12));
               end
            end
         end
      endcase
      return w;
   endfunction

   task automatic run_test(input logic [127:0] name, input int kind, input int count);
      int errors_before;
      int gap;
      int k;
      errors_before = errors;
      test_name     = name;
      for (int n = 0; n < count; n++) begin
         k = (kind == t_timing) ? int'(random_bits(2)) : kind;
         instr_valid <= 1'b1;
         instr       <= make_instr(k);
         @(posedge clk);
         if (kind == t_timing) gap = (random_bits(2) == 3) ? 1 + int'(random_bits(1)) : 0;
         else gap = int'(random_bits(2)) % 3;
         repeat (gap) begin
            instr_valid <= 1'b0;
            instr       <= random_bits(32); // Ignored without a strobe
            @(posedge clk);
         end
      end
      instr_valid <= 1'b0;
      repeat (3) @(posedge clk);
      tests_run++;
      $display("Test %0s done: %0d strobes, %0d errors", name, count, errors - errors_before);
   endtask

   initial begin
      #(n_total * 4 * 8);
      $display("Watchdog expired before the tests finished");
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      arst_n      = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      test_name   = "reset_state";
      repeat (3) begin
         @(posedge clk);
         instr_valid <= 1'(random_bits(1)); // Strobes under reset are dropped
         instr       <= random_bits(32);
      end
      arst_n      <= 1'b1;
      instr_valid <= 1'b0;
      repeat (n_reset) @(posedge clk);
      tests_run++;
      $display("Test reset_state done: %0d errors", errors);
      run_test("alu_decode", t_alu, n_alu);
      run_test("class_controls", t_class, n_class);
      run_test("system_decode", t_system, n_system);
      run_test("strobe_timing", t_timing, n_timing);
      run_test("unknown_opcode", t_unknown, n_unknown);
      $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- control_unit.f
hdl/ctrl_pkg.sv
hdl/alu_op_decode.sv
hdl/system_decode.sv
hdl/control_unit.sv
testbench/ctrl_checker.sv
testbench/tb_control_unit.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - files:
      - hdl/ctrl_pkg.sv
      - hdl/alu_op_decode.sv
      - hdl/system_decode.sv
      - hdl/control_unit.sv
  - target: test
    files:
      - testbench/ctrl_checker.sv
      - testbench/tb_control_unit.sv
